// ==== ex_alu.sv ====
//////////////////////////////
// Purely combinational ALU with one shared comparator
// Shift amount is operand B bits 4:0 only
// cmp_result_o is zero for non-compare opcodes
//////////////////////////////

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t            alu_req_i,
  output logic [ex_pkg::XLEN-1:0]     result_o,
  output logic                        cmp_result_o
);

  logic [ex_pkg::XLEN-1:0] op_a;
  logic [ex_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic                    cmp_signed;  // Signed compare select
  logic [ex_pkg::XLEN:0]   cmp_a;       // Operands extended by one bit
  logic [ex_pkg::XLEN:0]   cmp_b;
  logic [ex_pkg::XLEN:0]   cmp_diff;
  logic                    is_lt;
  logic                    is_eq;
  logic                    cmp_bit;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  assign shamt = op_b[4:0];

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign cmp_signed = (alu_req_i.op == ex_pkg::ALU_SLT) ||
                      (alu_req_i.op == ex_pkg::ALU_LT)  ||
                      (alu_req_i.op == ex_pkg::ALU_GE);

  // 33-bit difference never overflows, so its MSB is the less-than flag
  assign cmp_a    = {cmp_signed & op_a[ex_pkg::XLEN-1], op_a};
  assign cmp_b    = {cmp_signed & op_b[ex_pkg::XLEN-1], op_b};
  assign cmp_diff = cmp_a - cmp_b;
  assign is_lt    = cmp_diff[ex_pkg::XLEN];
  assign is_eq    = (op_a == op_b);

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ALU_EQ:                   cmp_bit = is_eq;
      ex_pkg::ALU_NE:                   cmp_bit = ~is_eq;
      ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
      ex_pkg::ALU_LT,  ex_pkg::ALU_LTU: cmp_bit = is_lt;
      ex_pkg::ALU_GE,  ex_pkg::ALU_GEU: cmp_bit = ~is_lt;
      default:                          cmp_bit = 1'b0;  // Arith and logic ops
    endcase
  end

  assign cmp_result_o = cmp_bit;

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ALU_ADD: result_o = op_a + op_b;
      ex_pkg::ALU_SUB: result_o = op_a - op_b;
      ex_pkg::ALU_AND: result_o = op_a & op_b;
      ex_pkg::ALU_OR:  result_o = op_a | op_b;
      ex_pkg::ALU_XOR: result_o = op_a ^ op_b;
      ex_pkg::ALU_SLL: result_o = op_a << shamt;
      ex_pkg::ALU_SRL: result_o = op_a >> shamt;
      ex_pkg::ALU_SRA: result_o = $unsigned($signed(op_a) >>> shamt);  // Sign fill
      default:         result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_bit};  // All compares
    endcase
  end

endmodule

// ==== ex_mult.sv ====
//////////////////////////////
// Integer multiplier on one 33x33 signed array
// MUL_LO and MUL_MAC finish in the request cycle
// MUL_HS and MUL_HU stall one cycle and then hold in HIGH
// until ex_ready_i. Request must stay stable meanwhile
//////////////////////////////

`timescale 1ns/1ps

module ex_mult (
  input  logic                        clk,
  input  logic                        rst_n,
  input  ex_pkg::mult_req_t           mult_req_i,
  input  logic                        ex_ready_i,
  output logic [ex_pkg::XLEN-1:0]     result_o,
  output logic                        valid_o,
  output logic                        ready_o,
  output logic                        multicycle_o
);

  typedef enum logic {
    IDLE = 1'b0,
    HIGH = 1'b1   // Upper half registered, waiting for EX to move
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic                            is_high_op;
  logic                            op_signed;
  logic signed [ex_pkg::XLEN:0]    op_a_ext;
  logic signed [ex_pkg::XLEN:0]    op_b_ext;
  logic signed [2*ex_pkg::XLEN-1:0] prod;
  logic [ex_pkg::XLEN-1:0]         prod_lo;
  logic [ex_pkg::XLEN-1:0]         prod_hi;
  logic [ex_pkg::XLEN-1:0]         hi_q;     // Stored upper half

  assign is_high_op = (mult_req_i.op == ex_pkg::MUL_HS) ||
                      (mult_req_i.op == ex_pkg::MUL_HU);
  assign op_signed  = (mult_req_i.op == ex_pkg::MUL_HS);

  // Low word is the same for either extension
  assign op_a_ext = {op_signed & mult_req_i.operand_a[ex_pkg::XLEN-1], mult_req_i.operand_a};
  assign op_b_ext = {op_signed & mult_req_i.operand_b[ex_pkg::XLEN-1], mult_req_i.operand_b};
  assign prod     = op_a_ext * op_b_ext;  // Low 64 bits of the exact product
  assign prod_lo  = prod[ex_pkg::XLEN-1:0];
  assign prod_hi  = prod[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    ready_o = 1'b1;
    valid_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (mult_req_i.en) begin
          if (is_high_op) begin
            ready_o = 1'b0;      // Stall EX one cycle
            state_d = HIGH;
          end else begin
            valid_o = 1'b1;      // Single cycle op done
          end
        end
      end
      HIGH: begin
        valid_o = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;        // Result consumed
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture upper half on entry to HIGH
  always_ff @(posedge clk) begin
    if (state_q == IDLE && mult_req_i.en && is_high_op) begin
      hi_q <= prod_hi;
    end
  end

  //////////////////////////////
  // Result
  //////////////////////////////

  always_comb begin
    if (state_q == HIGH) begin
      result_o = hi_q;
    end else begin
      case (mult_req_i.op)
        ex_pkg::MUL_LO:  result_o = prod_lo;
        ex_pkg::MUL_MAC: result_o = prod_lo + mult_req_i.operand_c;
        default:         result_o = prod_hi;  // Not yet valid in IDLE
      endcase
    end
  end

  assign multicycle_o = (state_q == HIGH);

endmodule

// ==== ex_pkg.sv ====
//////////////////////////////
// Shared widths, opcodes and port bundles of the execute stage
// Integer only. No FPU, vector or dot-product opcodes
// Opcode encodings are fixed and decoded by ID as is
//////////////////////////////

package ex_pkg;

  localparam int XLEN       = 32;  // Datapath width
  localparam int REG_ADDR_W = 6;   // Regfile address incl. upper bank bit

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // ALU opcodes, branch compares share the SLT comparator
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,  // Branch compares from here on
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,  // Low word, single cycle
    MUL_MAC = 2'd1,  // Low word plus operand C
    MUL_HS  = 2'd2,  // High word signed x signed, two cycles
    MUL_HU  = 2'd3   // High word unsigned x unsigned, two cycles
  } mult_op_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;  // Jump target rides here
  } alu_req_t;

  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;  // Accumulator for MAC
  } mult_req_t;

  // Regfile write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

// ==== ex_stage.sv ====
//////////////////////////////
// Execute stage top with ALU, multiplier and writeback
// ID must hold requests stable while ex_ready_o is low
//////////////////////////////

`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::alu_req_t              alu_req_i,
  input  ex_pkg::mult_req_t             mult_req_i,
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_err_i,
  input  logic                          lsu_ready_i,
  input  logic                          wb_ready_i,
  input  logic                          branch_in_ex_i,
  output ex_pkg::rf_wr_t                fw_o,
  output ex_pkg::rf_wr_t                wb_o,
  output logic                          branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  output logic                          mult_multicycle_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  logic [ex_pkg::XLEN-1:0] alu_result;
  logic [ex_pkg::XLEN-1:0] mult_result;
  logic                    mult_valid;
  logic                    mult_ready;

  assign jump_target_o = alu_req_i.operand_c;  // Target computed in ID

  ex_alu alu_inst (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult mult_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),       // Releases HIGH state
    .result_o     (mult_result),
    .valid_o      (mult_valid),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback writeback_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_req_i.en),
    .alu_result_i        (alu_result),
    .mult_valid_i        (mult_valid),
    .mult_result_i       (mult_result),
    .mult_ready_i        (mult_ready),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_err_i           (lsu_err_i),
    .lsu_ready_i         (lsu_ready_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .fw_o                (fw_o),
    .wb_o                (wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// ==== ex_stage_sva.sv ====
//////////////////////////////
// Handshake properties on the execute stage ports
// Bound into every ex_stage, idle during reset
//////////////////////////////

`timescale 1ns/1ps

module ex_stage_sva (
  input logic clk,
  input logic rst_n,
  input logic wb_ready_i,
  input logic branch_in_ex_i,
  input logic ex_valid_i,
  input logic ex_ready_i,
  input logic mult_multicycle_i
);

  // No result leaves EX while WB stalls
  valid_needs_wb_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else $error("ex_valid_o high while wb_ready_i is low");

  // Branches always retire
  branch_forces_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_i)
    else $error("ex_ready_o low with a branch in EX");

  // HIGH state ends once EX moves on
  high_state_releases: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_i && ex_ready_i) |=> !mult_multicycle_i)
    else $error("multiplier stayed in HIGH after ex_ready_o");

endmodule

bind ex_stage ex_stage_sva ex_stage_sva_inst (
  .clk               (clk),
  .rst_n             (rst_n),
  .wb_ready_i        (wb_ready_i),
  .branch_in_ex_i    (branch_in_ex_i),
  .ex_valid_i        (ex_valid_o),
  .ex_ready_i        (ex_ready_o),
  .mult_multicycle_i (mult_multicycle_o)
);

// ==== ex_writeback.sv ====
//////////////////////////////
// Forwarding port merge, EX/WB load register and stall logic
// wb_o.wdata is the raw LSU data of the WB cycle
// ex_valid_o never looks at ex_ready_o
//////////////////////////////

`timescale 1ns/1ps

module ex_writeback (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       alu_result_i,
  input  logic                          mult_valid_i,
  input  logic [ex_pkg::XLEN-1:0]       mult_result_i,
  input  logic                          mult_ready_i,
  input  logic                          csr_access_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                          lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_err_i,
  input  logic                          lsu_ready_i,
  input  logic                          wb_ready_i,
  input  logic                          branch_in_ex_i,
  output ex_pkg::rf_wr_t                fw_o,
  output ex_pkg::rf_wr_t                wb_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  logic                          units_ready;  // All EX users can advance
  logic                          load_we;      // Load writes back, no bus error
  logic                          wb_we_q;
  logic [ex_pkg::REG_ADDR_W-1:0] wb_waddr_q;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  always_comb begin
    fw_o.we    = regfile_alu_we_i;
    fw_o.waddr = regfile_alu_waddr_i;
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;       // CSR read wins
    end else if (mult_valid_i) begin
      fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_o.wdata = alu_result_i;
    end else begin
      fw_o.wdata = '0;
    end
  end

  //////////////////////////////
  // Stall and valid
  //////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;  // Branches retire in EX
  assign ex_valid_o  = (alu_en_i | mult_valid_i | csr_access_i | lsu_en_i) & units_ready;

  //////////////////////////////
  // EX/WB load register
  //////////////////////////////

  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= load_we;        // wb_ready_i implied by valid
    end else if (wb_ready_i) begin
      wb_we_q <= 1'b0;           // Bubble drains the slot
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  always_comb begin
    wb_o.we    = wb_we_q;
    wb_o.waddr = wb_waddr_q;
    wb_o.wdata = lsu_rdata_i;    // Data arrives in WB cycle
  end

endmodule

// ==== project.f ====
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
ex_stage_sva.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f project.f

out=$(./obj_dir/Vtb_ex_stage 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// ==== tb_ex_stage.sv ====
//////////////////////////////
// Directed testbench for the execute stage
// Inputs change 1 ns after the rising edge, outputs are read at the falling edge
// First failing check stops the run
//////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage;

  localparam int CLK_NS        = 100;
  localparam int ALU_ITERS     = 4;   // Random rounds per opcode
  localparam int TEST_CYCLES   = 3 + 16 * ALU_ITERS + 2 * ALU_ITERS + 12 + 4 + 5 + 4;
  localparam int MARGIN_CYCLES = 50;

  logic                          clk = 1'b0;
  logic                          rst_n;
  ex_pkg::alu_req_t              alu_req;
  ex_pkg::mult_req_t             mult_req;
  logic                          csr_access;
  logic [ex_pkg::XLEN-1:0]       csr_rdata;
  logic                          regfile_alu_we;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                          regfile_we;
  logic [ex_pkg::REG_ADDR_W-1:0] regfile_waddr;
  logic                          lsu_en;
  logic [ex_pkg::XLEN-1:0]       lsu_rdata;
  logic                          lsu_err;
  logic                          lsu_ready;
  logic                          wb_ready;
  logic                          branch_in_ex;
  ex_pkg::rf_wr_t                fw;
  ex_pkg::rf_wr_t                wb;
  logic                          branch_decision;
  logic [ex_pkg::XLEN-1:0]       jump_target;
  logic                          mult_multicycle;
  logic                          ex_ready;
  logic                          ex_valid;

  ex_stage ex_stage_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_err_i           (lsu_err),
    .lsu_ready_i         (lsu_ready),
    .wb_ready_i          (wb_ready),
    .branch_in_ex_i      (branch_in_ex),
    .fw_o                (fw),
    .wb_o                (wb),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;  // Drive point
  endtask

  task automatic drive_idle();
    alu_req = '0;
    mult_req = '0;
    csr_access = 1'b0;
    csr_rdata = '0;
    regfile_alu_we = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we = 1'b0;
    regfile_waddr = '0;
    lsu_en = 1'b0;
    lsu_rdata = '0;
    lsu_err = 1'b0;
    lsu_ready = 1'b1;
    wb_ready = 1'b1;     // No back-pressure by default
    branch_in_ex = 1'b0;
  endtask

  task automatic check_eq(input string test_name, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // {cmp bit, result} from the ALU rules
  function automatic logic [32:0] alu_model(input ex_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    logic        cmp;
    res = '0;
    cmp = 1'b0;
    case (op)
      ex_pkg::ALU_ADD:                  res = a + b;
      ex_pkg::ALU_SUB:                  res = a - b;
      ex_pkg::ALU_AND:                  res = a & b;
      ex_pkg::ALU_OR:                   res = a | b;
      ex_pkg::ALU_XOR:                  res = a ^ b;
      ex_pkg::ALU_SLL:                  res = a << b[4:0];
      ex_pkg::ALU_SRL:                  res = a >> b[4:0];
      ex_pkg::ALU_SRA:                  res = $signed(a) >>> b[4:0];
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT:  cmp = $signed(a) < $signed(b);
      ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: cmp = a < b;
      ex_pkg::ALU_EQ:                   cmp = a == b;
      ex_pkg::ALU_NE:                   cmp = a != b;
      ex_pkg::ALU_GE:                   cmp = $signed(a) >= $signed(b);
      default:                          cmp = a >= b;  // GEU
    endcase
    if (op > ex_pkg::ALU_SRA) res = {31'b0, cmp};  // Compares give the bit alone
    return {cmp, res};
  endfunction

  // Full 64-bit product, signed only for MUL_HS
  function automatic logic [63:0] mult_model(input ex_pkg::mult_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    a_ext = (op == ex_pkg::MUL_HS) ? {{32{a[31]}}, a} : {32'b0, a};
    b_ext = (op == ex_pkg::MUL_HS) ? {{32{b[31]}}, b} : {32'b0, b};
    return a_ext * b_ext;
  endfunction

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_alu_ops();
    logic [32:0] exp;
    string       name;
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < ALU_ITERS; k++) begin
        alu_req.en = 1'b1;
        alu_req.op = ex_pkg::alu_op_e'(i[3:0]);
        alu_req.operand_a = $urandom;
        alu_req.operand_b = (k == 0) ? alu_req.operand_a : $urandom;  // Hit equality
        if (k == 1) alu_req.operand_b[31] = ~alu_req.operand_a[31];   // Mixed signs
        alu_req.operand_c = $urandom;
        exp = alu_model(alu_req.op, alu_req.operand_a, alu_req.operand_b);
        name = $sformatf("alu_ops %s", alu_req.op.name());
        @(negedge clk);
        check_eq(name, "fw_o.wdata", exp[31:0], fw.wdata);
        check_eq(name, "branch_decision_o", {31'b0, exp[32]}, {31'b0, branch_decision});
        check_eq(name, "jump_target_o", alu_req.operand_c, jump_target);
        step();
      end
    end
    drive_idle();
  endtask

  task automatic test_mult_single();
    logic [63:0] exp;
    for (int i = 0; i < 2 * ALU_ITERS; i++) begin
      mult_req.en = 1'b1;
      mult_req.op = (i < ALU_ITERS) ? ex_pkg::MUL_LO : ex_pkg::MUL_MAC;
      mult_req.operand_a = $urandom;
      mult_req.operand_b = $urandom;
      mult_req.operand_c = $urandom;
      exp = mult_model(mult_req.op, mult_req.operand_a, mult_req.operand_b);
      if (mult_req.op == ex_pkg::MUL_MAC) exp = exp + mult_req.operand_c;
      @(negedge clk);
      check_eq("mult_single", "fw_o.wdata", exp[31:0], fw.wdata);
      check_eq("mult_single", "ex_ready_o", 1, ex_ready);  // No stall for low word
      step();
    end
    drive_idle();
  endtask

  task automatic test_mult_high();
    logic [63:0] prod;
    for (int i = 0; i < 4; i++) begin
      mult_req.en = 1'b1;
      mult_req.op = (i < 2) ? ex_pkg::MUL_HS : ex_pkg::MUL_HU;
      mult_req.operand_a = (i % 2 == 0) ? 32'hffff_ffff : $urandom;  // -1 vs 2^32-1
      mult_req.operand_b = (i % 2 == 0) ? 32'h0000_0002 : $urandom;
      prod = mult_model(mult_req.op, mult_req.operand_a, mult_req.operand_b);
      @(negedge clk);
      check_eq("mult_high", "ex_ready_o in stall", 0, ex_ready);
      check_eq("mult_high", "mult_multicycle_o in stall", 0, mult_multicycle);
      step();
      @(negedge clk);
      check_eq("mult_high", "ex_ready_o after stall", 1, ex_ready);
      check_eq("mult_high", "mult_multicycle_o", 1, mult_multicycle);
      check_eq("mult_high", "fw_o.wdata", prod[63:32], fw.wdata);
      step();
      drive_idle();
      @(negedge clk);
      check_eq("mult_high", "mult_multicycle_o back to idle", 0, mult_multicycle);
      step();
    end
  endtask

  task automatic test_fw_priority();
    logic [32:0] alu_exp;
    logic [63:0] prod;
    alu_req.en = 1'b1;
    alu_req.op = ex_pkg::ALU_ADD;
    alu_req.operand_a = $urandom;
    alu_req.operand_b = $urandom;
    mult_req.en = 1'b1;
    mult_req.op = ex_pkg::MUL_LO;
    mult_req.operand_a = $urandom;
    mult_req.operand_b = $urandom;
    csr_access = 1'b1;
    csr_rdata = $urandom;
    regfile_alu_we = 1'b1;
    regfile_alu_waddr = 6'($urandom);
    alu_exp = alu_model(ex_pkg::ALU_ADD, alu_req.operand_a, alu_req.operand_b);
    prod = mult_model(ex_pkg::MUL_LO, mult_req.operand_a, mult_req.operand_b);
    @(negedge clk);
    check_eq("fw_priority", "csr wdata", csr_rdata, fw.wdata);
    check_eq("fw_priority", "fw_o.we", 1, fw.we);
    check_eq("fw_priority", "fw_o.waddr", regfile_alu_waddr, fw.waddr);
    step();
    csr_access = 1'b0;
    @(negedge clk);
    check_eq("fw_priority", "mult wdata", prod[31:0], fw.wdata);
    step();
    mult_req.en = 1'b0;
    @(negedge clk);
    check_eq("fw_priority", "alu wdata", alu_exp[31:0], fw.wdata);
    step();
    alu_req.en = 1'b0;
    regfile_alu_we = 1'b0;
    @(negedge clk);
    check_eq("fw_priority", "idle wdata", 0, fw.wdata);
    check_eq("fw_priority", "fw_o.we off", 0, fw.we);
    step();
    drive_idle();
  endtask

  task automatic test_load_path();
    logic [5:0]  addr;
    logic [31:0] data;
    addr = 6'($urandom);
    data = $urandom;
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    regfile_waddr = addr;
    @(negedge clk);
    check_eq("load_path", "ex_valid_o", 1, ex_valid);
    step();
    drive_idle();
    lsu_rdata = data;   // Data shows up in the WB cycle
    @(negedge clk);
    check_eq("load_path", "wb_o.we", 1, wb.we);
    check_eq("load_path", "wb_o.waddr", addr, wb.waddr);
    check_eq("load_path", "wb_o.wdata", data, wb.wdata);
    step();             // Idle cycle drained the slot
    @(negedge clk);
    check_eq("load_path", "wb_o.we after bubble", 0, wb.we);
    step();
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    regfile_waddr = ~addr;
    lsu_err = 1'b1;     // Bus error blocks the write
    step();
    drive_idle();
    @(negedge clk);
    check_eq("load_path", "wb_o.we on error", 0, wb.we);
    check_eq("load_path", "wb_o.waddr kept", addr, wb.waddr);
    step();
  endtask

  task automatic test_back_pressure();
    logic [5:0] addr;
    addr = 6'($urandom);
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    regfile_waddr = addr;
    step();
    wb_ready = 1'b0;
    alu_req.en = 1'b1;
    regfile_waddr = ~addr;   // Must not be captured
    @(negedge clk);
    check_eq("back_pressure", "ex_ready_o", 0, ex_ready);
    check_eq("back_pressure", "ex_valid_o", 0, ex_valid);
    check_eq("back_pressure", "wb_o.we", 1, wb.we);
    step();
    @(negedge clk);
    check_eq("back_pressure", "wb_o.we held", 1, wb.we);
    check_eq("back_pressure", "wb_o.waddr held", addr, wb.waddr);
    step();
    branch_in_ex = 1'b1;
    @(negedge clk);
    check_eq("back_pressure", "ex_ready_o with branch", 1, ex_ready);
    check_eq("back_pressure", "ex_valid_o with branch", 0, ex_valid);
    step();
    drive_idle();
  endtask

  //////////////////////////////
  // Run
  //////////////////////////////

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_NS);
    $display("Watchdog expired, tests did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    void'($urandom(32'hd32361a7));  // Seeds the whole run
    drive_idle();
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("reset", "wb_o.we", 0, wb.we);
    check_eq("reset", "mult_multicycle_o", 0, mult_multicycle);
    step();
    test_alu_ops();
    test_mult_single();
    test_mult_high();
    test_fw_priority();
    test_load_path();
    test_back_pressure();
    $display(">>> PASS");
    $finish;
  end

endmodule
